// File: design/status_pkg.sv
package status_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;
    localparam int len_w  = 8;
    localparam int strb_w = 4;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [id_w-1:0]   id_t;
    typedef logic [len_w-1:0]  len_t;
    typedef logic [strb_w-1:0] strb_t;

    localparam logic [1:0] burst_fixed = 2'd0;
    localparam logic [1:0] burst_incr  = 2'd1;

    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_slverr = 2'd2;

    // register map, one word per address
    localparam addr_t addr_rst_status   = 32'h0000_0000; // bus reset status, ro
    localparam addr_t addr_rst_ctrl     = 32'h0000_0001; // bus reset pulses, wo
    localparam addr_t addr_uid_hi       = 32'h0000_0002;
    localparam addr_t addr_uid_lo       = 32'h0000_0003;
    localparam addr_t addr_power_status = 32'h0000_0004;
    localparam addr_t addr_power_reset  = 32'h0000_0005; // wo
    localparam addr_t addr_cam_size     = 32'h0000_000C; // {height, width}
    localparam addr_t addr_cam_ctrl     = 32'h0000_000D;
    localparam addr_t addr_ts_rst       = 32'h0000_000E;
    localparam addr_t addr_last         = 32'h0000_000E;

    localparam logic [15:0] cam_width_default  = 16'd640;
    localparam logic [15:0] cam_height_default = 16'd480;

    localparam int ts_rst_cycles = 64;
    localparam int ts_cnt_w      = $clog2(ts_rst_cycles);

    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } halves_t;

    typedef struct packed {
        logic [22:0] pad_hi;
        logic        pdn;    // bit 8
        logic [6:0]  pad_lo;
        logic        rstn;   // bit 0
    } ccd_t;

    typedef union packed {
        halves_t halves;
        ccd_t    ccd;
    } reg_word_u;

    // holes between 0x5 and 0xC and anything past the top of the map
    function automatic logic addr_unmapped(input addr_t addr);
        return (addr > addr_last) || ((addr > addr_power_reset) && (addr < addr_cam_size));
    endfunction

endpackage

// File: design/status_wr_channel.sv
module status_wr_channel (
    input  logic               clk,
    input  logic               STATUS_SLAVE_RSTN_SYNC,
    input  status_pkg::id_t    aw_id,
    input  status_pkg::addr_t  aw_addr,
    input  logic [1:0]         aw_burst,
    input  logic               aw_valid,
    output logic               aw_ready,
    input  logic               w_last,
    input  logic               w_valid,
    output logic               w_ready,
    input  logic               b_ready,
    output status_pkg::id_t    b_id,
    output logic [1:0]         b_resp,
    output logic               b_valid,
    output logic               wr_beat,
    output status_pkg::addr_t  wr_addr
);
    import status_pkg::*;

    typedef enum logic [1:0] {
        wr_idle,
        wr_data,
        wr_resp
    } wr_state_t;

    wr_state_t  state, state_nxt;
    logic [1:0] burst_q;
    logic       beat_err;
    logic       err_q;   // sticky over the burst
    logic       aw_hs;

    assign aw_hs    = aw_valid && aw_ready;
    assign aw_ready = (state == wr_idle);
    assign w_ready  = (state == wr_data);
    assign b_valid  = (state == wr_resp);
    assign wr_beat  = w_valid && w_ready;

    always_comb begin
        state_nxt = state;
        case (state)
            wr_idle: if (aw_hs) state_nxt = wr_data;
            wr_data: if (wr_beat && w_last) state_nxt = wr_resp;
            wr_resp: if (b_ready) state_nxt = wr_idle;
            default: state_nxt = wr_idle;
        endcase
    end

    // bad burst type, hole or past the map, or a read-only uid word
    assign beat_err = ((burst_q != burst_fixed) && (burst_q != burst_incr))
                    || addr_unmapped(wr_addr)
                    || (wr_addr == addr_uid_hi) || (wr_addr == addr_uid_lo);

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            state   <= wr_idle;
            burst_q <= burst_fixed;
            wr_addr <= '0;
            err_q   <= 1'b0;
        end else begin
            state <= state_nxt;
            if (aw_hs) begin
                burst_q <= aw_burst;
                wr_addr <= aw_addr;
                err_q   <= 1'b0;     // new burst starts clean
            end else if (wr_beat) begin
                if (burst_q == burst_incr) wr_addr <= wr_addr + 1'b1;
                if (beat_err) err_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) b_id <= aw_id;
    end

    assign b_resp = err_q ? resp_slverr : resp_okay;

endmodule

// File: design/status_rd_channel.sv
module status_rd_channel (
    input  logic               clk,
    input  logic               STATUS_SLAVE_RSTN_SYNC,
    input  status_pkg::id_t    ar_id,
    input  status_pkg::addr_t  ar_addr,
    input  status_pkg::len_t   ar_len,
    input  logic [1:0]         ar_burst,
    input  logic               ar_valid,
    output logic               ar_ready,
    input  logic               r_ready,
    input  status_pkg::data_t  rd_word,
    output status_pkg::id_t    r_id,
    output status_pkg::data_t  r_data,
    output logic [1:0]         r_resp,
    output logic               r_last,
    output logic               r_valid,
    output logic               rd_active,
    output status_pkg::addr_t  rd_addr
);
    import status_pkg::*;

    typedef enum logic {
        rd_idle,
        rd_data
    } rd_state_t;

    rd_state_t  state;
    len_t       len_q;
    len_t       beat_cnt;  // beats already taken
    logic [1:0] burst_q;
    logic       beat_err;
    logic       err_q;
    logic       rd_err;
    logic       ar_hs;
    logic       r_hs;

    assign ar_ready  = (state == rd_idle);
    assign r_valid   = (state == rd_data);
    assign rd_active = (state == rd_data);
    assign ar_hs     = ar_valid && ar_ready;
    assign r_hs      = r_valid && r_ready;
    assign r_last    = r_valid && (beat_cnt == len_q);

    // bad burst, unmapped word, or a write-only pulse register
    assign beat_err = ((burst_q != burst_fixed) && (burst_q != burst_incr))
                    || addr_unmapped(rd_addr)
                    || (rd_addr == addr_rst_ctrl) || (rd_addr == addr_power_reset);

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            state    <= rd_idle;
            len_q    <= '0;
            beat_cnt <= '0;
            burst_q  <= burst_fixed;
            rd_addr  <= '0;
            err_q    <= 1'b0;
        end else if (ar_hs) begin
            state    <= rd_data;
            len_q    <= ar_len;
            beat_cnt <= '0;
            burst_q  <= ar_burst;
            rd_addr  <= ar_addr;
            err_q    <= 1'b0;
        end else if (r_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (burst_q == burst_incr) rd_addr <= rd_addr + 1'b1;
            if (beat_err) err_q <= 1'b1;
            if (r_last) state <= rd_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) r_id <= ar_id;
    end

    assign rd_err = err_q || beat_err;  // sticky from first bad beat
    assign r_resp = rd_err ? resp_slverr : resp_okay;
    assign r_data = rd_err ? '1 : rd_word;

endmodule

// File: design/status_reg_bank.sv
module status_reg_bank (
    input  logic               clk,
    input  logic               STATUS_SLAVE_RSTN_SYNC,
    input  logic               wr_beat,
    input  status_pkg::addr_t  wr_addr,
    input  status_pkg::data_t  w_data,
    input  status_pkg::strb_t  w_strb,
    output logic [15:0]        bus_master_reset,
    output logic [15:0]        bus_slave_reset,
    output logic [7:0]         power_status,
    output logic [7:0]         power_reset,
    output logic [15:0]        cam_width,
    output logic [15:0]        cam_height,
    output logic               cam_rstn,
    output logic               cam_pdn,
    output logic               ts_wr,
    output logic               ts_wdata
);
    import status_pkg::*;

    reg_word_u wword;

    assign wword = w_data;

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            bus_master_reset <= '0;
            bus_slave_reset  <= '0;
            power_status     <= '0;
            power_reset      <= '0;
            cam_width        <= cam_width_default;
            cam_height       <= cam_height_default;
            cam_rstn         <= 1'b1;   // ccd out of reset
            cam_pdn          <= 1'b0;
        end else begin
            // pulses last one cycle unless the next beat sets them again
            bus_master_reset <= '0;
            bus_slave_reset  <= '0;
            power_reset      <= '0;
            if (wr_beat) begin
                case (wr_addr)
                    addr_rst_ctrl: begin
                        if (w_strb[3]) bus_master_reset[15:8] <= wword.halves.hi[15:8];
                        if (w_strb[2]) bus_master_reset[7:0]  <= wword.halves.hi[7:0];
                        if (w_strb[1]) bus_slave_reset[15:8]  <= wword.halves.lo[15:8];
                        if (w_strb[0]) bus_slave_reset[7:0]   <= wword.halves.lo[7:0];
                    end
                    addr_power_status: begin
                        if (w_strb[0]) power_status <= wword.halves.lo[7:0];
                    end
                    addr_power_reset: begin
                        if (w_strb[0]) power_reset <= wword.halves.lo[7:0];
                    end
                    addr_cam_size: begin
                        if (w_strb[3]) cam_height[15:8] <= wword.halves.hi[15:8];
                        if (w_strb[2]) cam_height[7:0]  <= wword.halves.hi[7:0];
                        if (w_strb[1]) cam_width[15:8]  <= wword.halves.lo[15:8];
                        if (w_strb[0]) cam_width[7:0]   <= wword.halves.lo[7:0];
                    end
                    addr_cam_ctrl: begin
                        if (w_strb[1]) cam_pdn  <= wword.ccd.pdn;
                        if (w_strb[0]) cam_rstn <= wword.ccd.rstn;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // timestamp reset level lives in the timer
    assign ts_wr    = wr_beat && (wr_addr == addr_ts_rst) && w_strb[0];
    assign ts_wdata = w_data[0];

endmodule

// File: design/timestamp_rst_timer.sv
module timestamp_rst_timer (
    input  logic clk,
    input  logic STATUS_SLAVE_RSTN_SYNC,
    input  logic ts_wr,
    input  logic ts_wdata,
    output logic ts_rst
);
    import status_pkg::*;

    logic [ts_cnt_w-1:0] hold_cnt;  // cycles since the set beat

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            ts_rst   <= 1'b0;
            hold_cnt <= '0;
        end else if (ts_wr) begin
            ts_rst   <= ts_wdata;   // rewrite restarts or cancels
            hold_cnt <= '0;
        end else if (ts_rst) begin
            if (hold_cnt == ts_cnt_w'(ts_rst_cycles - 1)) begin
                ts_rst   <= 1'b0;
                hold_cnt <= '0;
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

endmodule

// File: design/status_read_mux.sv
module status_read_mux (
    input  status_pkg::addr_t  rd_addr,
    input  logic               rd_active,
    input  logic [15:0]        bus_master_rstn_status,
    input  logic [15:0]        bus_slave_rstn_status,
    input  status_pkg::data_t  uid_hi,
    input  status_pkg::data_t  uid_lo,
    input  logic [7:0]         power_status,
    input  logic [15:0]        cam_width,
    input  logic [15:0]        cam_height,
    input  logic               cam_rstn,
    input  logic               cam_pdn,
    input  logic               ts_rst,
    output status_pkg::data_t  rd_word
);
    import status_pkg::*;

    reg_word_u word;

    always_comb begin
        word = '0;
        if (rd_active) begin
            case (rd_addr)
                addr_rst_status: begin
                    word.halves.hi = bus_master_rstn_status;
                    word.halves.lo = bus_slave_rstn_status;
                end
                addr_uid_hi:       word = uid_hi;
                addr_uid_lo:       word = uid_lo;
                addr_power_status: word = {24'b0, power_status};
                addr_cam_size: begin
                    word.halves.hi = cam_height;
                    word.halves.lo = cam_width;
                end
                addr_cam_ctrl: begin
                    word.ccd.pdn  = cam_pdn;
                    word.ccd.rstn = cam_rstn;
                end
                addr_ts_rst:       word = {31'b0, ts_rst};
                default:           word = '1;  // unmapped or write only
            endcase
        end
    end

    assign rd_word = word;

endmodule

// File: design/sys_status_slave.sv
module sys_status_slave (
    input  logic               clk,
    input  logic               STATUS_SLAVE_RSTN_SYNC,
    input  status_pkg::id_t    aw_id,
    input  status_pkg::addr_t  aw_addr,
    input  logic [1:0]         aw_burst,
    input  logic               aw_valid,
    output logic               aw_ready,
    input  status_pkg::data_t  w_data,
    input  status_pkg::strb_t  w_strb,
    input  logic               w_last,
    input  logic               w_valid,
    output logic               w_ready,
    output status_pkg::id_t    b_id,
    output logic [1:0]         b_resp,
    output logic               b_valid,
    input  logic               b_ready,
    input  status_pkg::id_t    ar_id,
    input  status_pkg::addr_t  ar_addr,
    input  status_pkg::len_t   ar_len,
    input  logic [1:0]         ar_burst,
    input  logic               ar_valid,
    output logic               ar_ready,
    output status_pkg::id_t    r_id,
    output status_pkg::data_t  r_data,
    output logic [1:0]         r_resp,
    output logic               r_last,
    output logic               r_valid,
    input  logic               r_ready,
    input  logic [15:0]        bus_master_rstn_status,
    input  logic [15:0]        bus_slave_rstn_status,
    input  status_pkg::data_t  uid_hi,
    input  status_pkg::data_t  uid_lo,
    output logic [15:0]        bus_master_reset,
    output logic [15:0]        bus_slave_reset,
    output logic [7:0]         power_status,
    output logic [7:0]         power_reset,
    output logic [15:0]        cam_width,
    output logic [15:0]        cam_height,
    output logic               cam_rstn,
    output logic               cam_pdn,
    output logic               ts_rst
);
    import status_pkg::*;

    logic  wr_beat;
    addr_t wr_addr;
    logic  ts_wr;
    logic  ts_wdata;
    addr_t rd_addr;
    logic  rd_active;
    data_t rd_word;   // mux word before error substitution

    status_wr_channel u_wr_channel (.*);

    status_rd_channel u_rd_channel (.*);

    status_reg_bank u_reg_bank (.*);

    timestamp_rst_timer u_ts_timer (.*);

    status_read_mux u_read_mux (.*);

endmodule

// File: test/status_properties.sv
module status_properties (
    input logic              clk,
    input logic              STATUS_SLAVE_RSTN_SYNC,
    input status_pkg::id_t   aw_id,
    input status_pkg::id_t   ar_id,
    input status_pkg::id_t   b_id,
    input status_pkg::id_t   r_id,
    input status_pkg::addr_t aw_addr,
    input status_pkg::addr_t ar_addr,
    input status_pkg::len_t  ar_len,
    input logic [1:0]        aw_burst,
    input logic [1:0]        ar_burst,
    input logic [1:0]        b_resp,
    input logic [1:0]        r_resp,
    input status_pkg::data_t w_data,
    input status_pkg::data_t r_data,
    input status_pkg::data_t uid_hi,
    input status_pkg::data_t uid_lo,
    input status_pkg::strb_t w_strb,
    input logic              aw_valid, aw_ready, w_valid, w_ready, b_valid,
    input logic              ar_valid, ar_ready, r_valid, r_ready, r_last,
    input logic [15:0]       bus_master_rstn_status, bus_slave_rstn_status,
    input logic [15:0]       bus_master_reset, bus_slave_reset, cam_width, cam_height,
    input logic [7:0]        power_status, power_reset,
    input logic              cam_rstn, cam_pdn, ts_rst
);
    import status_pkg::*;

    int        err_cnt = 0;   // read by the testbench at the end
    addr_t     wa, ra;
    logic[1:0] wburst, rburst;
    len_t      rlen, rcnt;
    id_t       bid, rid;
    logic      werr, rerr, wbad, rbad, wbeat;
    data_t     wmask, sh_cam, exp_rdata;
    logic[7:0] sh_pwr, exp_p;
    logic[15:0] exp_m, exp_s;
    logic      sh_pdn, sh_rstn;

    function automatic logic hole(input addr_t a);
        return (a > 32'hE) || ((a > 32'h5) && (a < 32'hC));
    endfunction

    assign wbeat = w_valid && w_ready;
    assign wmask = {{8{w_strb[3]}}, {8{w_strb[2]}}, {8{w_strb[1]}}, {8{w_strb[0]}}};
    assign wbad  = (wburst > 2'd1) || hole(wa) || (wa == 32'h2) || (wa == 32'h3);
    assign rbad  = (rburst > 2'd1) || hole(ra) || (ra == 32'h1) || (ra == 32'h5);

    always_comb begin
        case (ra)
            32'h0:   exp_rdata = {bus_master_rstn_status, bus_slave_rstn_status};
            32'h2:   exp_rdata = uid_hi;
            32'h3:   exp_rdata = uid_lo;
            32'h4:   exp_rdata = {24'b0, sh_pwr};
            32'hC:   exp_rdata = sh_cam;
            32'hD:   exp_rdata = {23'b0, sh_pdn, 7'b0, sh_rstn};
            32'hE:   exp_rdata = {31'b0, ts_rst};
            default: exp_rdata = '1;
        endcase
        if (rerr || rbad) exp_rdata = '1;   // error word from the first bad beat on
    end

    always_ff @(posedge clk or negedge STATUS_SLAVE_RSTN_SYNC) begin
        if (!STATUS_SLAVE_RSTN_SYNC) begin
            {wa, ra, wburst, rburst, rlen, rcnt, bid, rid, werr, rerr} <= '0;
            {sh_pwr, exp_m, exp_s, exp_p, sh_pdn} <= '0;
            sh_cam  <= {16'd480, 16'd640};
            sh_rstn <= 1'b1;
        end else begin
            exp_m <= (wbeat && wa == 32'h1) ? (w_data[31:16] & wmask[31:16]) : 16'h0;
            exp_s <= (wbeat && wa == 32'h1) ? (w_data[15:0] & wmask[15:0]) : 16'h0;
            exp_p <= (wbeat && wa == 32'h5) ? (w_data[7:0] & wmask[7:0]) : 8'h0;
            if (aw_valid && aw_ready) begin
                {wa, wburst, bid, werr} <= {aw_addr, aw_burst, aw_id, 1'b0};
            end else if (wbeat) begin
                if (wbad) werr <= 1'b1;
                if (wburst == 2'd1) wa <= wa + 1;
                if (wa == 32'h4 && w_strb[0]) sh_pwr <= w_data[7:0];
                if (wa == 32'hC) sh_cam <= (sh_cam & ~wmask) | (w_data & wmask);
                if (wa == 32'hD && w_strb[1]) sh_pdn <= w_data[8];
                if (wa == 32'hD && w_strb[0]) sh_rstn <= w_data[0];
            end
            if (ar_valid && ar_ready) begin
                {ra, rburst, rlen, rid, rcnt, rerr} <= {ar_addr, ar_burst, ar_len, ar_id, 9'b0};
            end else if (r_valid && r_ready) begin
                rcnt <= rcnt + 1;
                if (rburst == 2'd1) ra <= ra + 1;
                if (rbad) rerr <= 1'b1;
            end
        end
    end

    a_reset: assert property (@(posedge clk) $rose(STATUS_SLAVE_RSTN_SYNC) |->
        aw_ready && ar_ready && !w_ready && !b_valid && !r_valid && !ts_rst && !cam_pdn
        && cam_rstn && cam_width == 16'd640 && cam_height == 16'd480
        && bus_master_reset == 0 && bus_slave_reset == 0 && power_reset == 0)
        else begin
            err_cnt++;
            $error("outputs not at their reset values");
        end

    a_rdata: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        r_valid |-> r_data == exp_rdata)
        else begin
            err_cnt++;
            $error("ERR %0t r_data exp %h got %h", $time, exp_rdata, r_data);
        end

    a_rresp: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        r_valid |-> r_resp == ((rerr || rbad) ? 2'd2 : 2'd0))
        else begin
            err_cnt++;
            $error("ERR %0t r_resp exp %0d got %0d", $time,
                   (rerr || rbad) ? 2 : 0, r_resp);
        end

    a_rlast: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        r_valid |-> r_last == (rcnt == rlen) && r_id == rid)
        else begin
            err_cnt++;
            $error("ERR %0t r_last/r_id exp %b/%h got %b/%h", $time,
                   rcnt == rlen, rid, r_last, r_id);
        end

    a_bresp: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        b_valid |-> b_resp == (werr ? 2'd2 : 2'd0) && b_id == bid)
        else begin
            err_cnt++;
            $error("ERR %0t b_resp/b_id exp %0d/%h got %0d/%h", $time,
                   werr ? 2 : 0, bid, b_resp, b_id);
        end

    a_bus_pulse: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        bus_master_reset == exp_m && bus_slave_reset == exp_s)
        else begin
            err_cnt++;
            $error("ERR %0t bus_master_reset/bus_slave_reset exp %h/%h got %h/%h", $time,
                   exp_m, exp_s, bus_master_reset, bus_slave_reset);
        end

    a_power_pulse: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        power_reset == exp_p)
        else begin
            err_cnt++;
            $error("ERR %0t power_reset exp %h got %h", $time, exp_p, power_reset);
        end

    a_cam: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        {cam_height, cam_width} == sh_cam && cam_pdn == sh_pdn && cam_rstn == sh_rstn)
        else begin
            err_cnt++;
            $error("ERR %0t cam_height,cam_width/cam_pdn,cam_rstn exp %h/%b%b got %h/%b%b",
                   $time, sh_cam, sh_pdn, sh_rstn, {cam_height, cam_width}, cam_pdn, cam_rstn);
        end

    a_power: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        power_status == sh_pwr)
        else begin
            err_cnt++;
            $error("ERR %0t power_status exp %h got %h", $time, sh_pwr, power_status);
        end

    a_ts: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        wbeat && wa == 32'hE && w_strb[0] && w_data[0] |=> ts_rst [*64] ##1 !ts_rst)
        else begin
            err_cnt++;
            $error("ts_rst was not held for 64 cycles after a write of 1");
        end

    a_stable: assert property (@(posedge clk) disable iff (!STATUS_SLAVE_RSTN_SYNC)
        r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_resp) && $stable(r_last))
        else begin
            err_cnt++;
            $error("read beat changed while r_ready was low");
        end

endmodule

bind sys_status_slave status_properties u_props (.*);

// File: test/tb_sys_status_slave.sv
module tb_sys_status_slave;
    import status_pkg::*;

    localparam int limit = 200;   // cycles per wait

    logic clk, STATUS_SLAVE_RSTN_SYNC;
    id_t aw_id, ar_id, b_id, r_id;
    addr_t aw_addr, ar_addr;
    len_t ar_len;
    logic [1:0] aw_burst, ar_burst, b_resp, r_resp;
    data_t w_data, r_data, uid_hi, uid_lo;
    strb_t w_strb;
    logic aw_valid, aw_ready, w_last, w_valid, w_ready, b_valid, b_ready;
    logic ar_valid, ar_ready, r_last, r_valid, r_ready;
    logic [15:0] bus_master_rstn_status, bus_slave_rstn_status;
    logic [15:0] bus_master_reset, bus_slave_reset, cam_width, cam_height;
    logic [7:0] power_status, power_reset;
    logic cam_rstn, cam_pdn, ts_rst;
    logic [31:0] lfsr = 32'hc884c936;
    int timeouts = 0;
    int total;

    sys_status_slave uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_cycle(inout int guard, input string what);
        tick();
        guard++;
        if (guard > limit) begin
            timeouts++;
            $display("timeout at %0t while waiting for %s", $time, what);
        end
    endtask

    task automatic bus_write(input addr_t addr, input logic [1:0] burst, input int beats,
                             input data_t set_data, input strb_t set_strb);
        int g;
        {aw_addr, aw_burst, aw_id, aw_valid} = {addr, burst, 4'(rand_bits(4)), 1'b1};
        g = 0;
        while (!aw_ready && g <= limit) wait_cycle(g, "aw_ready");
        tick();
        aw_valid = 1'b0;
        for (int i = 0; i < beats; i++) begin
            w_data = rand_bits(32) | set_data;
            w_strb = 4'(rand_bits(4)) | set_strb;
            w_last = (i == beats - 1);
            repeat (rand_bits(2)) tick();   // idle gaps between beats
            w_valid = 1'b1;
            g = 0;
            while (!w_ready && g <= limit) wait_cycle(g, "w_ready");
            tick();
            w_valid = 1'b0;
        end
        repeat (rand_bits(2)) tick();
        b_ready = 1'b1;
        g = 0;
        while (!b_valid && g <= limit) wait_cycle(g, "b_valid");
        tick();
        b_ready = 1'b0;
    endtask

    task automatic bus_read(input addr_t addr, input len_t len, input logic [1:0] burst);
        int g;
        {bus_master_rstn_status, bus_slave_rstn_status} = rand_bits(32);
        uid_hi = rand_bits(32);
        uid_lo = rand_bits(32);
        {ar_addr, ar_len, ar_burst, ar_id, ar_valid} = {addr, len, burst, 4'(rand_bits(4)), 1'b1};
        g = 0;
        while (!ar_ready && g <= limit) wait_cycle(g, "ar_ready");
        tick();
        ar_valid = 1'b0;
        for (int i = 0; i <= len; i++) begin
            repeat (rand_bits(2)) tick();   // back-pressure on r
            r_ready = 1'b1;
            g = 0;
            while (!r_valid && g <= limit) wait_cycle(g, "r_valid");
            tick();
            r_ready = 1'b0;
        end
    endtask

    initial begin
        int g;
        STATUS_SLAVE_RSTN_SYNC = 1'b0;
        {aw_id, aw_addr, aw_burst, aw_valid, w_data, w_strb, w_last, w_valid, b_ready} = '0;
        {ar_id, ar_addr, ar_len, ar_burst, ar_valid, r_ready} = '0;
        {bus_master_rstn_status, bus_slave_rstn_status, uid_hi, uid_lo} = '0;
        repeat (10) @(posedge clk);
        #2 STATUS_SLAVE_RSTN_SYNC = 1'b1;
        tick();
        bus_write(32'h4, burst_incr, 1, 0, 4'h1);
        bus_read(32'h4, 0, burst_incr);
        bus_write(32'hC, burst_incr, 2, 0, 0);  // size then ccd control
        bus_read(32'hC, 1, burst_incr);
        bus_write(32'hD, burst_fixed, 1, 0, 4'h3);
        bus_read(32'hD, 2, burst_fixed);
        bus_read(32'h0, 0, burst_incr);
        bus_read(32'h2, 1, burst_incr);
        bus_write(32'h1, burst_fixed, 1, 0, 0);
        bus_write(32'h5, burst_fixed, 3, 0, 0);
        bus_write(32'h2, burst_incr, 1, 0, 0);
        bus_write(32'hF, burst_incr, 1, 0, 0);
        bus_write(32'h0, 2'd2, 1, 0, 0);        // wrap burst
        bus_read(32'h1, 0, burst_incr);
        bus_read(32'h5, 0, burst_fixed);
        bus_read(32'h7, 0, burst_incr);
        bus_read(32'h3, 3, burst_incr);         // error part way through
        bus_write(32'hE, burst_incr, 1, 32'h1, 4'h1);
        g = 0;
        while (ts_rst && g <= limit) wait_cycle(g, "ts_rst to clear");
        repeat (4) tick();
        total = uut.u_props.err_cnt + timeouts;
        $display("assertion errors %0d, timeouts %0d", uut.u_props.err_cnt, timeouts);
        if (total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: filelist.f
design/status_pkg.sv
design/status_wr_channel.sv
design/status_rd_channel.sv
design/status_reg_bank.sv
design/timestamp_rst_timer.sv
design/status_read_mux.sv
design/sys_status_slave.sv
test/status_properties.sv
test/tb_sys_status_slave.sv
